//--- hw/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// user read-only counter aliases
`define CSR_CYCLE          12'hC00
`define CSR_INSTRET        12'hC02
`define CSR_CYCLEH         12'hC80
`define CSR_INSTRETH       12'hC82

`define CSR_MSTATUS        12'h300
`define CSR_MISA           12'h301
`define CSR_MIE            12'h304
`define CSR_MTVEC          12'h305
`define CSR_MCOUNTINHIBIT  12'h320
`define CSR_MSCRATCH       12'h340
`define CSR_MEPC           12'h341
`define CSR_MCAUSE         12'h342
`define CSR_MTVAL          12'h343
`define CSR_MIP            12'h344
`define CSR_MCYCLE         12'hB00
`define CSR_MINSTRET       12'hB02
`define CSR_MCYCLEH        12'hB80
`define CSR_MINSTRETH      12'hB82

// RV32 with I, M and U
`define MISA_VALUE         32'h4010_1100

`define MSTATUS_MIE_BIT    3
`define MSTATUS_MPIE_BIT   7
`define MSTATUS_MPP_LSB    11

// shared by mie and mip
`define IRQ_MSI_BIT        3
`define IRQ_MTI_BIT        7
`define IRQ_MEI_BIT        11

`define CNT_CY_BIT         0
`define CNT_IR_BIT         2

`define MPIE_RESET         1'b1
`define MTVEC_BASE_RESET   30'h0

`endif

//--- hw/csr_pkg.sv
package csr_pkg;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    typedef enum logic [1:0] {
        MTVEC_DIRECT   = 2'b00,
        MTVEC_VECTORED = 2'b01
    } mtvec_mode_e;

    typedef enum logic [4:0] {
        EXC_INSTR_MISALIGNED  = 5'd0,
        EXC_INSTR_ACCESS      = 5'd1,
        EXC_ILLEGAL_INSTR     = 5'd2,
        EXC_BREAKPOINT        = 5'd3,
        EXC_LOAD_MISALIGNED   = 5'd4,
        EXC_LOAD_ACCESS       = 5'd5,
        EXC_STORE_MISALIGNED  = 5'd6,
        EXC_STORE_ACCESS      = 5'd7,
        EXC_ECALL_U           = 5'd8,
        EXC_ECALL_M           = 5'd11
    } exc_cause_e;

    typedef enum logic [4:0] {
        IRQ_M_SOFT  = 5'd3,
        IRQ_M_TIMER = 5'd7,
        IRQ_M_EXT   = 5'd11
    } irq_cause_e;

    // one CSR-type instruction in execute
    typedef struct packed {
        logic        en;
        logic        read;
        logic        write;
        logic        mret;
        logic [11:0] addr;
        logic [31:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic        exc_valid;
        exc_cause_e  exc_cause;
        logic [31:0] exc_value;
        logic        irq_valid;
        irq_cause_e  irq_cause;
    } trap_req_t;

    // one-hot, user counter aliases fold onto the machine counters
    typedef struct packed {
        logic mstatus;
        logic misa;
        logic mie;
        logic mip;
        logic mtvec;
        logic mscratch;
        logic mepc;
        logic mcause;
        logic mtval;
        logic mcycle;
        logic mcycleh;
        logic minstret;
        logic minstreth;
        logic mcountinhibit;
    } csr_sel_t;

    typedef struct packed {
        logic mie;
        logic meie;
        logic mtie;
        logic msie;
    } csr_cfg_t;

endpackage

//--- hw/csr_decode.sv
`include "csr_consts.svh"

module csr_decode (
    input  csr_pkg::csr_req_t req,
    input  csr_pkg::priv_e    priv,
    input  logic              exc_valid,
    output csr_pkg::csr_sel_t sel,
    output logic              wr_en,
    output logic              mret_ok,
    output logic              illegal_instr
);

    logic [11:0] addr;
    logic        m_mode;
    logic        user_ctr;
    logic        known;
    logic        legal_read;
    logic        legal_write;

    assign addr   = req.addr;
    assign m_mode = (priv == csr_pkg::PRIV_M);

    assign user_ctr = (addr == `CSR_CYCLE) || (addr == `CSR_CYCLEH) ||
                      (addr == `CSR_INSTRET) || (addr == `CSR_INSTRETH);

    always_comb begin
        sel               = '0;
        sel.mstatus       = (addr == `CSR_MSTATUS);
        sel.misa          = (addr == `CSR_MISA);
        sel.mie           = (addr == `CSR_MIE);
        sel.mip           = (addr == `CSR_MIP);
        sel.mtvec         = (addr == `CSR_MTVEC);
        sel.mscratch      = (addr == `CSR_MSCRATCH);
        sel.mepc          = (addr == `CSR_MEPC);
        sel.mcause        = (addr == `CSR_MCAUSE);
        sel.mtval         = (addr == `CSR_MTVAL);
        sel.mcycle        = (addr == `CSR_MCYCLE) || (addr == `CSR_CYCLE);
        sel.mcycleh       = (addr == `CSR_MCYCLEH) || (addr == `CSR_CYCLEH);
        sel.minstret      = (addr == `CSR_MINSTRET) || (addr == `CSR_INSTRET);
        sel.minstreth     = (addr == `CSR_MINSTRETH) || (addr == `CSR_INSTRETH);
        sel.mcountinhibit = (addr == `CSR_MCOUNTINHIBIT);
    end

    assign known = |sel;

    // user mode only sees the counter aliases
    assign legal_read  = m_mode ? known : user_ctr;
    // aliases are read-only, misa writes are accepted and ignored
    assign legal_write = m_mode & known & ~user_ctr;

    assign illegal_instr = req.en & ((req.read & ~legal_read) |
                                     (req.write & ~legal_write) |
                                     (req.mret & ~m_mode));

    assign wr_en   = req.en & req.write & ~illegal_instr & ~exc_valid;
    assign mret_ok = req.en & req.mret & m_mode;

endmodule

//--- hw/csr_machine_state.sv
`include "csr_consts.svh"

module csr_machine_state (
    input  logic                 clk,
    input  logic                 rst_n,
    input  csr_pkg::csr_sel_t    sel,
    input  logic                 wr_en,
    input  logic                 mret_ok,
    input  logic [31:0]          wdata,
    input  csr_pkg::trap_req_t   trap,
    input  logic [31:0]          pc,
    input  logic                 irq_ext,
    input  logic                 irq_timer,
    output csr_pkg::priv_e       priv,
    output csr_pkg::csr_cfg_t    cfg,
    output logic                 next_pc_valid,
    output logic [31:0]          next_pc,
    output logic [31:0]          mstatus_word,
    output logic [31:0]          mie_word,
    output logic [31:0]          mip_word,
    output logic [31:0]          mtvec_word,
    output logic [31:0]          mscratch,
    output logic [31:0]          mepc,
    output logic [31:0]          mcause,
    output logic [31:0]          mtval
);

    logic                 st_mie;
    logic                 st_mpie;
    csr_pkg::priv_e       st_mpp;
    logic                 en_msie;
    logic                 en_mtie;
    logic                 en_meie;
    logic                 pend_msip;
    logic [29:0]          mtvec_base;
    csr_pkg::mtvec_mode_e mtvec_mode;
    logic [29:0]          mepc_base;
    logic                 trap_take;
    logic                 mpp_ok;
    logic                 mode_ok;
    logic [1:0]           wr_mpp;

    assign trap_take = trap.irq_valid | trap.exc_valid;
    assign wr_mpp    = wdata[`MSTATUS_MPP_LSB +: 2];

    // WARL, only M and U exist for mpp
    assign mpp_ok  = (wr_mpp == csr_pkg::PRIV_M) || (wr_mpp == csr_pkg::PRIV_U);
    assign mode_ok = (wdata[1:0] == csr_pkg::MTVEC_DIRECT) ||
                     (wdata[1:0] == csr_pkg::MTVEC_VECTORED);

    // trap wins over mret, mret over a CSR write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            priv    <= csr_pkg::PRIV_M;
            st_mie  <= 1'b0;
            st_mpie <= `MPIE_RESET;
            st_mpp  <= csr_pkg::PRIV_U;
        end else if (trap_take) begin
            priv    <= csr_pkg::PRIV_M;
            st_mie  <= 1'b0;
            st_mpie <= st_mie;
            st_mpp  <= priv;
        end else if (mret_ok) begin
            priv    <= st_mpp;
            st_mie  <= st_mpie;
            st_mpie <= 1'b1;
            st_mpp  <= csr_pkg::PRIV_U;
        end else if (wr_en && sel.mstatus) begin
            st_mie  <= wdata[`MSTATUS_MIE_BIT];
            st_mpie <= wdata[`MSTATUS_MPIE_BIT];
            if (mpp_ok) begin
                st_mpp <= csr_pkg::priv_e'(wr_mpp);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_msie    <= 1'b0;
            en_mtie    <= 1'b0;
            en_meie    <= 1'b0;
            pend_msip  <= 1'b0;
            mtvec_base <= `MTVEC_BASE_RESET;
            mtvec_mode <= csr_pkg::MTVEC_DIRECT;
            mscratch   <= 32'h0;
        end else if (wr_en) begin
            if (sel.mie) begin
                en_msie <= wdata[`IRQ_MSI_BIT];
                en_mtie <= wdata[`IRQ_MTI_BIT];
                en_meie <= wdata[`IRQ_MEI_BIT];
            end
            if (sel.mip) begin
                pend_msip <= wdata[`IRQ_MSI_BIT];
            end
            if (sel.mtvec) begin
                mtvec_base <= wdata[31:2];
                if (mode_ok) begin
                    mtvec_mode <= csr_pkg::mtvec_mode_e'(wdata[1:0]);
                end
            end
            if (sel.mscratch) begin
                mscratch <= wdata;
            end
        end
    end

    // trap capture, interrupt takes cause and value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_base <= 30'h0;
            mcause    <= 32'h0;
            mtval     <= 32'h0;
        end else if (trap_take) begin
            mepc_base <= pc[31:2];
            if (trap.irq_valid) begin
                mcause <= {1'b1, 26'h0, trap.irq_cause};
                mtval  <= 32'h0;
            end else begin
                mcause <= {27'h0, trap.exc_cause};
                mtval  <= trap.exc_value;
            end
        end else if (wr_en) begin
            if (sel.mepc) begin
                mepc_base <= wdata[31:2];
            end
            if (sel.mcause) begin
                mcause <= wdata;
            end
            if (sel.mtval) begin
                mtval <= wdata;
            end
        end
    end

    always_comb begin
        next_pc_valid = 1'b0;
        next_pc       = 32'h0;
        if (trap_take) begin
            next_pc_valid = 1'b1;
            if (mtvec_mode == csr_pkg::MTVEC_VECTORED && trap.irq_valid) begin
                next_pc = {mtvec_base + 30'(trap.irq_cause), 2'b00};
            end else begin
                next_pc = {mtvec_base, 2'b00};
            end
        end else if (mret_ok) begin
            next_pc_valid = 1'b1;
            next_pc       = mepc;
        end
    end

    always_comb begin
        mstatus_word                            = 32'h0;
        mstatus_word[`MSTATUS_MIE_BIT]          = st_mie;
        mstatus_word[`MSTATUS_MPIE_BIT]         = st_mpie;
        mstatus_word[`MSTATUS_MPP_LSB +: 2]     = st_mpp;
        mie_word                                = 32'h0;
        mie_word[`IRQ_MSI_BIT]                  = en_msie;
        mie_word[`IRQ_MTI_BIT]                  = en_mtie;
        mie_word[`IRQ_MEI_BIT]                  = en_meie;
        mip_word                                = 32'h0;
        mip_word[`IRQ_MSI_BIT]                  = pend_msip;
        mip_word[`IRQ_MTI_BIT]                  = irq_timer;
        mip_word[`IRQ_MEI_BIT]                  = irq_ext;
    end

    assign mtvec_word = {mtvec_base, mtvec_mode};
    assign mepc       = {mepc_base, 2'b00};

    assign cfg.mie  = st_mie;
    assign cfg.meie = en_meie;
    assign cfg.mtie = en_mtie;
    assign cfg.msie = en_msie;

endmodule

//--- hw/csr_counters.sv
`include "csr_consts.svh"

module csr_counters (
    input  logic              clk,
    input  logic              rst_n,
    input  csr_pkg::csr_sel_t sel,
    input  logic              wr_en,
    input  logic [31:0]       wdata,
    input  logic              instr_done,
    input  logic              exc_valid,
    output logic [63:0]       mcycle,
    output logic [63:0]       minstret,
    output logic [31:0]       mcountinhibit_word
);

    logic inhibit_cy;
    logic inhibit_ir;
    logic cy_inc;
    logic ir_inc;

    // written half replaces, the other keeps its incremented value
    function automatic logic [63:0] next_count(
        input logic [63:0] cur,
        input logic        inc,
        input logic        wr_lo,
        input logic        wr_hi,
        input logic [31:0] data
    );
        logic [63:0] nxt;
        nxt = cur + 64'(inc);
        if (wr_lo) begin
            nxt[31:0] = data;
        end else if (wr_hi) begin
            nxt[63:32] = data;
        end
        return nxt;
    endfunction

    assign cy_inc = ~inhibit_cy;
    assign ir_inc = ~inhibit_ir & instr_done & ~exc_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcycle     <= 64'h0;
            minstret   <= 64'h0;
            inhibit_cy <= 1'b0;
            inhibit_ir <= 1'b0;
        end else begin
            mcycle   <= next_count(mcycle, cy_inc, wr_en & sel.mcycle,
                                   wr_en & sel.mcycleh, wdata);
            minstret <= next_count(minstret, ir_inc, wr_en & sel.minstret,
                                   wr_en & sel.minstreth, wdata);
            if (wr_en && sel.mcountinhibit) begin
                inhibit_cy <= wdata[`CNT_CY_BIT];
                inhibit_ir <= wdata[`CNT_IR_BIT];
            end
        end
    end

    always_comb begin
        mcountinhibit_word              = 32'h0;
        mcountinhibit_word[`CNT_CY_BIT] = inhibit_cy;
        mcountinhibit_word[`CNT_IR_BIT] = inhibit_ir;
    end

endmodule

//--- hw/csr_read_mux.sv
`include "csr_consts.svh"

module csr_read_mux (
    input  csr_pkg::csr_sel_t sel,
    input  logic [31:0]       mstatus_word,
    input  logic [31:0]       mie_word,
    input  logic [31:0]       mip_word,
    input  logic [31:0]       mtvec_word,
    input  logic [31:0]       mscratch,
    input  logic [31:0]       mepc,
    input  logic [31:0]       mcause,
    input  logic [31:0]       mtval,
    input  logic [63:0]       mcycle,
    input  logic [63:0]       minstret,
    input  logic [31:0]       mcountinhibit_word,
    output logic [31:0]       rdata
);

    // and-or over a one-hot select, nothing selected reads zero
    assign rdata = ({32{sel.mstatus}}       & mstatus_word)       |
                   ({32{sel.misa}}          & `MISA_VALUE)        |
                   ({32{sel.mie}}           & mie_word)           |
                   ({32{sel.mip}}           & mip_word)           |
                   ({32{sel.mtvec}}         & mtvec_word)         |
                   ({32{sel.mscratch}}      & mscratch)           |
                   ({32{sel.mepc}}          & mepc)               |
                   ({32{sel.mcause}}        & mcause)             |
                   ({32{sel.mtval}}         & mtval)              |
                   ({32{sel.mcycle}}        & mcycle[31:0])       |
                   ({32{sel.mcycleh}}       & mcycle[63:32])      |
                   ({32{sel.minstret}}      & minstret[31:0])     |
                   ({32{sel.minstreth}}     & minstret[63:32])    |
                   ({32{sel.mcountinhibit}} & mcountinhibit_word);

endmodule

//--- hw/csr_top.sv
module csr_top (
    input  logic               clk,
    input  logic               rst_n,
    input  csr_pkg::csr_req_t  req,
    input  csr_pkg::trap_req_t trap,
    input  logic [31:0]        pc,
    input  logic               instr_done,
    input  logic               irq_ext,
    input  logic               irq_timer,
    output logic [31:0]        rdata,
    output logic               illegal_instr,
    output logic               next_pc_valid,
    output logic [31:0]        next_pc,
    output csr_pkg::priv_e     priv,
    output csr_pkg::csr_cfg_t  cfg
);

    csr_pkg::csr_sel_t sel;
    logic              wr_en;
    logic              mret_ok;
    logic [31:0]       mstatus_word;
    logic [31:0]       mie_word;
    logic [31:0]       mip_word;
    logic [31:0]       mtvec_word;
    logic [31:0]       mscratch;
    logic [31:0]       mepc;
    logic [31:0]       mcause;
    logic [31:0]       mtval;
    logic [63:0]       mcycle;
    logic [63:0]       minstret;
    logic [31:0]       mcountinhibit_word;

    csr_decode u_decode (
        .req           (req),
        .priv          (priv),
        .exc_valid     (trap.exc_valid),
        .sel           (sel),
        .wr_en         (wr_en),
        .mret_ok       (mret_ok),
        .illegal_instr (illegal_instr)
    );

    csr_machine_state u_state (
        .clk           (clk),
        .rst_n         (rst_n),
        .sel           (sel),
        .wr_en         (wr_en),
        .mret_ok       (mret_ok),
        .wdata         (req.wdata),
        .trap          (trap),
        .pc            (pc),
        .irq_ext       (irq_ext),
        .irq_timer     (irq_timer),
        .priv          (priv),
        .cfg           (cfg),
        .next_pc_valid (next_pc_valid),
        .next_pc       (next_pc),
        .mstatus_word  (mstatus_word),
        .mie_word      (mie_word),
        .mip_word      (mip_word),
        .mtvec_word    (mtvec_word),
        .mscratch      (mscratch),
        .mepc          (mepc),
        .mcause        (mcause),
        .mtval         (mtval)
    );

    csr_counters u_counters (
        .clk                (clk),
        .rst_n              (rst_n),
        .sel                (sel),
        .wr_en              (wr_en),
        .wdata              (req.wdata),
        .instr_done         (instr_done),
        .exc_valid          (trap.exc_valid),
        .mcycle             (mcycle),
        .minstret           (minstret),
        .mcountinhibit_word (mcountinhibit_word)
    );

    csr_read_mux u_read_mux (
        .sel                (sel),
        .mstatus_word       (mstatus_word),
        .mie_word           (mie_word),
        .mip_word           (mip_word),
        .mtvec_word         (mtvec_word),
        .mscratch           (mscratch),
        .mepc               (mepc),
        .mcause             (mcause),
        .mtval              (mtval),
        .mcycle             (mcycle),
        .minstret           (minstret),
        .mcountinhibit_word (mcountinhibit_word),
        .rdata              (rdata)
    );

endmodule

//--- bench/tb_csr.sv
`include "csr_consts.svh"

module tb_csr;
    timeunit 1ns;
    timeprecision 100ps;

    localparam string TRACE_PATH = "bench/csr_trace.txt";
    // polls are 1 ns apart, one clock period is 4 ns
    localparam int EDGE_POLLS = 8;

    logic               clk;
    logic               rst_n;
    csr_pkg::csr_req_t  req;
    csr_pkg::trap_req_t trap;
    logic [31:0]        pc;
    logic               instr_done;
    logic               irq_ext;
    logic               irq_timer;
    logic [31:0]        rdata;
    logic               illegal_instr;
    logic               next_pc_valid;
    logic [31:0]        next_pc;
    csr_pkg::priv_e     priv;
    csr_pkg::csr_cfg_t  cfg;

    int edge_count;
    int errors;
    int tests;
    int failed_tests;
    bit timed_out;
    // meie, mtie, msie as last written to mie
    logic [2:0] mie_expect;

    csr_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .trap          (trap),
        .pc            (pc),
        .instr_done    (instr_done),
        .irq_ext       (irq_ext),
        .irq_timer     (irq_timer),
        .rdata         (rdata),
        .illegal_instr (illegal_instr),
        .next_pc_valid (next_pc_valid),
        .next_pc       (next_pc),
        .priv          (priv),
        .cfg           (cfg)
    );

    initial begin
        clk        = 1'b0;
        edge_count = 0;
        forever begin
            #2;
            clk = ~clk;
            if (clk) begin
                edge_count++;
            end
        end
    end

    // called half a ns off the clock grid, returns 1 ns after the edge
    task automatic next_edge();
        int start;
        int polls;
        start = edge_count;
        polls = 0;
        while (edge_count == start && polls < EDGE_POLLS) begin
            #1;
            polls++;
        end
        if (edge_count == start) begin
            timed_out = 1'b1;
            $display("timeout: no rising clock edge within %0d ns", EDGE_POLLS);
        end
        #0.5;
    endtask

    task automatic drive_inputs(
        input string       kind,
        input logic [31:0] arg,
        input logic [31:0] data,
        input logic [31:0] pc_val,
        input logic [31:0] flags
    );
        req        = '0;
        trap       = '0;
        pc         = pc_val;
        instr_done = flags[3];
        if (kind == "write") begin
            req.en    = 1'b1;
            req.write = 1'b1;
            req.addr  = arg[11:0];
            req.wdata = data;
        end else if (kind == "read") begin
            req.en   = 1'b1;
            req.read = 1'b1;
            req.addr = arg[11:0];
        end else if (kind == "mret") begin
            req.en   = 1'b1;
            req.mret = 1'b1;
        end else if (kind == "trap") begin
            // top bit of the cause marks an interrupt
            if (arg[31]) begin
                trap.irq_valid = 1'b1;
                trap.irq_cause = csr_pkg::irq_cause_e'(arg[4:0]);
            end else begin
                trap.exc_valid = 1'b1;
                trap.exc_cause = csr_pkg::exc_cause_e'(arg[4:0]);
                trap.exc_value = data;
            end
        end
    endtask

    task automatic check_outputs(
        input int          line_no,
        input string       kind,
        input logic [31:0] exp,
        input logic [31:0] flags
    );
        assert (illegal_instr == flags[0]) else begin
            $display("error %0t: line %0d %s illegal_instr %b, expected %b",
                     $time, line_no, kind, illegal_instr, flags[0]);
            errors++;
        end
        assert (next_pc_valid == flags[1]) else begin
            $display("error %0t: line %0d %s next_pc_valid %b, expected %b",
                     $time, line_no, kind, next_pc_valid, flags[1]);
            errors++;
        end
        if (flags[1]) begin
            assert (next_pc == exp) else begin
                $display("error %0t: line %0d %s next_pc %h, expected %h",
                         $time, line_no, kind, next_pc, exp);
                errors++;
            end
        end
        assert ((priv == csr_pkg::PRIV_U) == flags[2]) else begin
            $display("error %0t: line %0d %s priv %b, expected user mode %b",
                     $time, line_no, kind, priv, flags[2]);
            errors++;
        end
        assert ({cfg.meie, cfg.mtie, cfg.msie} == mie_expect) else begin
            $display("error %0t: line %0d %s cfg enables %b, expected %b",
                     $time, line_no, kind, {cfg.meie, cfg.mtie, cfg.msie}, mie_expect);
            errors++;
        end
        // read data of a trapped read is not defined
        if (kind == "read" && !flags[0]) begin
            assert (rdata == exp) else begin
                $display("error %0t: line %0d read of %h gave %h, expected %h",
                         $time, line_no, req.addr, rdata, exp);
                errors++;
            end
            if (req.addr == `CSR_MSTATUS) begin
                assert (cfg.mie == exp[`MSTATUS_MIE_BIT]) else begin
                    $display("error %0t: line %0d cfg.mie %b, expected %b",
                             $time, line_no, cfg.mie, exp[`MSTATUS_MIE_BIT]);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        int          fd;
        int          line_no;
        int          fields;
        int          count;
        int          cyc;
        int          errors_before;
        string       line;
        string       kind;
        logic [31:0] arg;
        logic [31:0] data;
        logic [31:0] pc_val;
        logic [31:0] exp;
        logic [31:0] flags;
        rst_n        = 1'b0;
        req          = '0;
        trap         = '0;
        pc           = 32'h0;
        instr_done   = 1'b0;
        irq_ext      = 1'b0;
        irq_timer    = 1'b0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        mie_expect   = 3'b000;
        line_no      = 0;
        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0) begin
            $display("could not open the trace file %s", TRACE_PATH);
            errors++;
        end
        #0.5;
        next_edge();
        #0.5;
        next_edge();
        rst_n = 1'b1;
        #1.5;
        while (fd != 0 && !timed_out && $fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h %h %h %h", kind, arg, data, pc_val, exp, flags);
            if (fields != 6) begin
                $display("trace line %0d could not be parsed", line_no);
                errors++;
                continue;
            end
            if (kind != "write" && kind != "read" && kind != "trap" &&
                kind != "mret" && kind != "idle") begin
                $display("trace line %0d has an unknown operation %s", line_no, kind);
                errors++;
                continue;
            end
            errors_before = errors;
            count = (kind == "idle") ? int'(arg) : 1;
            cyc = 0;
            while (cyc < count && !timed_out) begin
                next_edge();
                if (!timed_out) begin
                    drive_inputs(kind, arg, data, pc_val, flags);
                    #1.5;
                    check_outputs(line_no, kind, exp, flags);
                end
                cyc++;
            end
            // a legal mie write shows on cfg from the next cycle on
            if (kind == "write" && arg[11:0] == `CSR_MIE && !flags[0]) begin
                mie_expect = {data[`IRQ_MEI_BIT], data[`IRQ_MTI_BIT], data[`IRQ_MSI_BIT]};
            end
            if (!timed_out) begin
                tests++;
                if (errors == errors_before) begin
                    $display("test %0d line %0d %s: ok", tests, line_no, kind);
                end else begin
                    failed_tests++;
                    $display("test %0d line %0d %s: failed", tests, line_no, kind);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("tests %0d, passed %0d, failed %0d",
                 tests, tests - failed_tests, failed_tests);
        if (errors == 0 && !timed_out && tests > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- bench/csr_trace.txt
# op    addr/cause data     pc       expect   flags   (all hex, idle takes a cycle count)
# flags: 1 illegal_instr, 2 next_pc_valid, 4 priv is U, 8 instr_done driven high
read    300        0        0        00000080 0
read    301        0        0        40101100 0
write   340        12345678 0        0        0
read    340        0        0        12345678 0
write   341        80000403 0        0        0
read    341        0        0        80000400 0
write   305        00001001 0        0        0
write   305        00002003 0        0        0
read    305        0        0        00002001 0
write   305        00000100 0        0        0
write   300        00001088 0        0        0
read    300        0        0        00000088 0
trap    00000002   deadbeef 00000400 00000100 2
read    341        0        0        00000400 0
read    342        0        0        00000002 0
read    343        0        0        deadbeef 0
read    300        0        0        00001880 0
write   305        00000201 0        0        0
trap    8000000b   0        00000500 0000022c 2
read    342        0        0        8000000b 0
read    300        0        0        00001800 0
write   300        00000080 0        0        0
write   341        00000800 0        0        0
write   b00        00001000 0        0        0
mret    0          0        0        00000800 2
write   340        0        0        0        5
read    300        0        0        0        5
read    c00        0        0        00001003 4
mret    0          0        0        0        5
trap    00000008   0        00000600 00000200 6
read    300        0        0        00000080 0
read    340        0        0        12345678 0
write   b00        00000100 0        0        0
idle    5          0        0        0        0
read    b00        0        0        00000105 0
write   320        00000001 0        0        0
idle    3          0        0        0        0
read    b00        0        0        00000107 0
write   b02        0        0        0        0
idle    4          0        0        0        8
trap    00000005   00001234 00000700 00000200 a
trap    80000007   0        00000710 0000021c a
idle    2          0        0        0        0
read    c02        0        0        00000005 0

//--- project.f
+incdir+hw
hw/csr_pkg.sv
hw/csr_decode.sv
hw/csr_machine_state.sv
hw/csr_counters.sv
hw/csr_read_mux.sv
hw/csr_top.sv
bench/tb_csr.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --timescale 1ns/100ps -f project.f --top-module tb_csr \
        -o tb_csr_sim \
    && ./obj_dir/tb_csr_sim | tee /dev/stderr | grep -q -F '** PASS **' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
